// File: Bender.yml
package:
  name: bumpy

sources:
  - bumpy_pkg.sv
  - bumpy_control.sv
  - bumpy_move.sv
  - bumpy_hit_detect.sv
  - bumpy_top.sv
  - target: test
    files:
      - bumpy_tb.sv

// File: bumpy_control.sv
`timescale 1ns/1ps
`default_nettype none

module bumpy_control (
	input  logic clk,
	input  logic resetN,
	input  logic key_left,
	input  logic key_right,
	input  logic key_up,
	input  logic key_down,
	input  logic key_die,
	input  logic collision,
	input  bumpy_pkg::edge_t hit_edge,
	output bumpy_pkg::bumpy_state_t state
);

	bumpy_pkg::bumpy_state_t state_next;

	logic any_key;
	logic hit_left;
	logic hit_right;
	logic hit_top;
	logic hit_bottom;

	assign any_key = key_left | key_right | key_up | key_down | key_die;

	// edge code only counts while the collision pulse is up
	assign hit_left = collision && (hit_edge == bumpy_pkg::EDGE_LEFT);
	assign hit_right = collision && (hit_edge == bumpy_pkg::EDGE_RIGHT);
	assign hit_top = collision && (hit_edge == bumpy_pkg::EDGE_TOP);
	assign hit_bottom = collision && (hit_edge == bumpy_pkg::EDGE_BOTTOM);

	always_comb begin
		state_next = state;
		case (state)
			bumpy_pkg::s_reset:
				state_next = bumpy_pkg::s_idle;
			bumpy_pkg::s_idle: begin
				if (key_die) // die wins over every move
					state_next = bumpy_pkg::s_die;
				else if (key_left)
					state_next = bumpy_pkg::s_left;
				else if (key_right)
					state_next = bumpy_pkg::s_right;
				else if (key_up)
					state_next = bumpy_pkg::s_up;
				else if (key_down)
					state_next = bumpy_pkg::s_down;
			end
			bumpy_pkg::s_left: begin
				if (hit_left)
					state_next = bumpy_pkg::s_bounce_from_left;
				else if (!key_left)
					state_next = bumpy_pkg::s_idle;
			end
			bumpy_pkg::s_right: begin
				if (hit_right)
					state_next = bumpy_pkg::s_bounce_from_right;
				else if (!key_right)
					state_next = bumpy_pkg::s_idle;
			end
			bumpy_pkg::s_up: begin
				if (hit_top)
					state_next = bumpy_pkg::s_bounce_from_top;
				else if (!key_up)
					state_next = bumpy_pkg::s_idle;
			end
			bumpy_pkg::s_bounce_from_left: begin
				if (key_down)
					state_next = bumpy_pkg::s_down_from_left;
				else if (!any_key)
					state_next = bumpy_pkg::s_idle;
			end
			bumpy_pkg::s_bounce_from_right: begin
				if (key_down)
					state_next = bumpy_pkg::s_down_from_right;
				else if (!any_key)
					state_next = bumpy_pkg::s_idle;
			end
			bumpy_pkg::s_bounce_from_top: begin
				if (key_down) // no side drift off the ceiling
					state_next = bumpy_pkg::s_down;
				else if (!any_key)
					state_next = bumpy_pkg::s_idle;
			end
			bumpy_pkg::s_down, bumpy_pkg::s_down_from_left, bumpy_pkg::s_down_from_right: begin
				if (hit_bottom) // landed
					state_next = bumpy_pkg::s_idle;
			end
			bumpy_pkg::s_die: begin
				if (key_down)
					state_next = bumpy_pkg::s_down;
			end
			default:
				state_next = bumpy_pkg::s_idle;
		endcase
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			state <= bumpy_pkg::s_reset;
		else
			state <= state_next;
	end

endmodule

`default_nettype wire

// File: bumpy_hit_detect.sv
`timescale 1ns/1ps
`default_nettype none

module bumpy_hit_detect (
	input  logic clk,
	input  logic resetN,
	input  logic pos_valid,
	input  bumpy_pkg::fix_t pos_x,
	input  bumpy_pkg::fix_t pos_y,
	output logic collision,
	output bumpy_pkg::edge_t hit_edge
);

	bumpy_pkg::fix_t bottom_y;
	bumpy_pkg::fix_t right_x;
	bumpy_pkg::edge_t edge_next;

	logic at_bottom;
	logic at_top;
	logic at_left;
	logic at_right;

	// far corner of the sprite
	assign bottom_y = pos_y + bumpy_pkg::BUMPY_SIZE_FIX;
	assign right_x = pos_x + bumpy_pkg::BUMPY_SIZE_FIX;

	assign at_bottom = bottom_y >= bumpy_pkg::FRAME_H_FIX;
	assign at_top = pos_y <= 0;
	assign at_left = pos_x < bumpy_pkg::BORDER_OFFSET;
	assign at_right = right_x > (bumpy_pkg::FRAME_W_FIX - bumpy_pkg::BORDER_OFFSET);

	// only the highest priority edge is reported
	always_comb begin
		if (at_bottom)
			edge_next = bumpy_pkg::EDGE_BOTTOM;
		else if (at_top)
			edge_next = bumpy_pkg::EDGE_TOP;
		else if (at_left)
			edge_next = bumpy_pkg::EDGE_LEFT;
		else if (at_right)
			edge_next = bumpy_pkg::EDGE_RIGHT;
		else
			edge_next = '0;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			collision <= 1'b0;
			hit_edge <= '0;
		end else begin
			collision <= pos_valid && (edge_next != '0); // one cycle since pos_valid is
			if (pos_valid)
				hit_edge <= edge_next;
		end
	end

endmodule

`default_nettype wire

// File: bumpy_move.sv
`timescale 1ns/1ps
`default_nettype none

module bumpy_move (
	input  logic clk,
	input  logic resetN,
	input  logic start_of_frame, // one-cycle strobe per video frame
	input  bumpy_pkg::bumpy_state_t state,
	input  logic collision,
	input  bumpy_pkg::edge_t hit_edge,
	output bumpy_pkg::fix_t pos_x,
	output bumpy_pkg::fix_t pos_y,
	output bumpy_pkg::pix_t offset_topleft_x,
	output bumpy_pkg::pix_t offset_topleft_y,
	output logic pos_valid,
	output logic dead_flag
);

	bumpy_pkg::fix_t speed_x;
	bumpy_pkg::fix_t speed_y;
	bumpy_pkg::fix_t jump_start_y; // floor height at the last take-off

	logic bottom_hit;
	logic past_left;
	logic past_right;
	logic jump_over;

	assign bottom_hit = collision && (hit_edge == bumpy_pkg::EDGE_BOTTOM);

	assign past_left = pos_x < bumpy_pkg::BORDER_OFFSET;
	assign past_right = (pos_x + bumpy_pkg::BUMPY_SIZE_FIX) >
		(bumpy_pkg::FRAME_W_FIX - bumpy_pkg::BORDER_OFFSET);

	// y grows downward so a high jump means a small pos_y
	assign jump_over = pos_y < (jump_start_y - bumpy_pkg::JUMP_LIMIT);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			jump_start_y <= bumpy_pkg::START_FIX;
		else if (bottom_hit)
			jump_start_y <= pos_y;
	end

	// horizontal speed
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speed_x <= '0;
		end else begin
			case (state)
				bumpy_pkg::s_left:
					speed_x <= -bumpy_pkg::SPEED;
				bumpy_pkg::s_right:
					speed_x <= bumpy_pkg::SPEED;
				bumpy_pkg::s_bounce_from_left, bumpy_pkg::s_bounce_from_right: begin
					if (past_left)
						speed_x <= bumpy_pkg::SPEED;
					else if (past_right)
						speed_x <= -bumpy_pkg::SPEED;
				end
				bumpy_pkg::s_down_from_left, bumpy_pkg::s_down_from_right:
					speed_x <= speed_x; // keep drifting sideways on the way down
				default:
					speed_x <= '0;
			endcase
		end
	end

	// vertical speed
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speed_y <= '0;
		end else begin
			case (state)
				bumpy_pkg::s_idle, bumpy_pkg::s_left, bumpy_pkg::s_right,
				bumpy_pkg::s_bounce_from_left, bumpy_pkg::s_bounce_from_right: begin
					if (bottom_hit && (speed_y >= 0)) // bounce off the floor
						speed_y <= -bumpy_pkg::SPEED;
					else if (speed_y == 0) // gravity
						speed_y <= bumpy_pkg::SPEED;
					else if ((speed_y < 0) && jump_over)
						speed_y <= bumpy_pkg::SPEED;
				end
				bumpy_pkg::s_up:
					speed_y <= -bumpy_pkg::SPEED;
				bumpy_pkg::s_bounce_from_top:
					speed_y <= bumpy_pkg::SPEED;
				bumpy_pkg::s_down, bumpy_pkg::s_down_from_left, bumpy_pkg::s_down_from_right:
					speed_y <= bottom_hit ? -bumpy_pkg::SPEED : bumpy_pkg::SPEED;
				default:
					speed_y <= '0; // reset and die freeze the sprite
			endcase
		end
	end

	// integrate once per frame
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pos_x <= bumpy_pkg::START_FIX;
			pos_y <= bumpy_pkg::START_FIX;
			pos_valid <= 1'b0;
		end else begin
			pos_valid <= start_of_frame; // fresh position for the border check
			if (start_of_frame) begin
				pos_x <= pos_x + speed_x;
				pos_y <= pos_y + speed_y;
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			dead_flag <= 1'b0;
		else if (state == bumpy_pkg::s_die)
			dead_flag <= 1'b1;
		else if (state == bumpy_pkg::s_down)
			dead_flag <= 1'b0;
	end

	assign offset_topleft_x = bumpy_pkg::pix_t'(pos_x >>> bumpy_pkg::FIXED_SHIFT);
	assign offset_topleft_y = bumpy_pkg::pix_t'(pos_y >>> bumpy_pkg::FIXED_SHIFT);

endmodule

`default_nettype wire

// File: bumpy_pkg.sv
`default_nettype none

package bumpy_pkg;

	typedef logic signed [17:0] fix_t; // position or speed in 1/64 pixel units
	typedef logic signed [10:0] pix_t; // screen coordinate in whole pixels
	typedef logic [3:0] edge_t; // one-hot border code

	// movement states of the sprite
	typedef enum logic [3:0] {
		s_reset,
		s_idle,
		s_left,
		s_right,
		s_down,
		s_up,
		s_die,
		s_bounce_from_left,
		s_bounce_from_right,
		s_bounce_from_top,
		s_down_from_right,
		s_down_from_left
	} bumpy_state_t;

	localparam int FIXED_SHIFT = 6; // 64 fixed units per pixel

	localparam fix_t FRAME_W_FIX = fix_t'(639 << FIXED_SHIFT);
	localparam fix_t FRAME_H_FIX = fix_t'(479 << FIXED_SHIFT);
	localparam fix_t BUMPY_SIZE_FIX = fix_t'(16 << FIXED_SHIFT);
	localparam fix_t START_FIX = fix_t'(8 << FIXED_SHIFT); // half a sprite from the corner

	localparam fix_t SPEED = 18'sd40; // per frame
	localparam fix_t JUMP_LIMIT = 18'sd200; // highest rise above the take-off point
	localparam fix_t BORDER_OFFSET = 18'sd40; // side margin

	localparam edge_t EDGE_BOTTOM = 4'b0001;
	localparam edge_t EDGE_RIGHT = 4'b0010;
	localparam edge_t EDGE_TOP = 4'b0100;
	localparam edge_t EDGE_LEFT = 4'b1000;

endpackage

`default_nettype wire

// File: bumpy_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bumpy_tb;

	localparam int FRAME_CYCLES = 16;
	localparam int LONG_RUN_FRAMES = 1100; // crossing the whole screen at one speed step
	localparam int SHORT_RUN_FRAMES = 40;
	// two long border runs and the short tests, plus half again as margin
	localparam int TIMEOUT_CYCLES =
		FRAME_CYCLES * (2 * LONG_RUN_FRAMES + 6 * SHORT_RUN_FRAMES) * 3 / 2;

	logic clk;
	logic resetN;
	logic start_of_frame;
	logic key_left;
	logic key_right;
	logic key_up;
	logic key_down;
	logic key_die;
	bumpy_pkg::pix_t offset_topleft_x;
	bumpy_pkg::pix_t offset_topleft_y;
	logic collision;
	bumpy_pkg::edge_t hit_edge;
	bumpy_pkg::bumpy_state_t state;
	logic dead_flag;

	int check_count = 0;
	int error_count = 0;
	int errors_before = 0;
	int cycle_count = 0;
	integer seed;
	logic hit_seen; // a collision came during the last frame
	bumpy_pkg::edge_t hit_code;
	int x_model; // reference position in fixed units
	int y_model;

	bumpy_top dut0 (
		.clk (clk),
		.resetN (resetN),
		.start_of_frame (start_of_frame),
		.key_left (key_left),
		.key_right (key_right),
		.key_up (key_up),
		.key_down (key_down),
		.key_die (key_die),
		.offset_topleft_x (offset_topleft_x),
		.offset_topleft_y (offset_topleft_y),
		.collision (collision),
		.hit_edge (hit_edge),
		.state (state),
		.dead_flag (dead_flag)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run was stopped after %0d cycles", cycle_count);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic compare_value(input string name, input logic signed [31:0] actual,
		input logic signed [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic confirm(input logic ok, input string what);
		check_count++;
		if (!ok) begin
			error_count++;
			$display("%s", what);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %-12s done, %0d errors", name, error_count - errors_before);
		errors_before = error_count;
	endtask

	task automatic apply_reset();
		start_of_frame = 1'b0;
		key_left = 1'b0;
		key_right = 1'b0;
		key_up = 1'b0;
		key_down = 1'b0;
		key_die = 1'b0;
		resetN = 1'b0;
		repeat (5) @(negedge clk);
		resetN = 1'b1;
		repeat (3) @(negedge clk); // idle, then gravity settles
	endtask

	// one strobe, then watch the rest of the frame for a collision pulse
	task automatic run_frame();
		hit_seen = 1'b0;
		hit_code = '0;
		start_of_frame = 1'b1;
		@(negedge clk);
		start_of_frame = 1'b0;
		repeat (FRAME_CYCLES - 1) begin
			@(negedge clk);
			if (collision) begin
				hit_seen = 1'b1;
				hit_code = hit_edge;
			end
		end
	endtask

	function automatic int to_pixel(input int fix);
		return fix >>> bumpy_pkg::FIXED_SHIFT;
	endfunction

	function automatic int pick_frames();
		return 3 + (($random(seed) & 32'h7fff_ffff) % 6); // 3 to 8
	endfunction

	task automatic reset_values();
		apply_reset();
		compare_value("offset_topleft_x", offset_topleft_x, to_pixel(bumpy_pkg::START_FIX));
		compare_value("offset_topleft_y", offset_topleft_y, to_pixel(bumpy_pkg::START_FIX));
		compare_value("dead_flag", dead_flag, 0);
		compare_value("collision", collision, 0);
		compare_value("state", state, bumpy_pkg::s_idle);
		end_test("reset");
	endtask

	task automatic walk_right();
		int frames;
		frames = pick_frames();
		apply_reset();
		x_model = bumpy_pkg::START_FIX;
		y_model = bumpy_pkg::START_FIX;
		key_right = 1'b1;
		repeat (3) @(negedge clk); // state first, speed one cycle later
		repeat (frames) begin
			run_frame();
			x_model += bumpy_pkg::SPEED;
			y_model += bumpy_pkg::SPEED; // gravity keeps pulling
			compare_value("offset_topleft_x", offset_topleft_x, to_pixel(x_model));
			compare_value("offset_topleft_y", offset_topleft_y, to_pixel(y_model));
			confirm(!hit_seen, "walk_right: unexpected collision in open space");
		end
		compare_value("state", state, bumpy_pkg::s_right);
		end_test("walk_right");
	endtask

	task automatic top_bounce();
		int frames;
		int n;
		int hit_pix;
		frames = pick_frames();
		apply_reset();
		y_model = bumpy_pkg::START_FIX;
		key_up = 1'b1;
		repeat (3) @(negedge clk);
		n = 0;
		hit_seen = 1'b0;
		while (!hit_seen && n < SHORT_RUN_FRAMES) begin
			run_frame();
			y_model -= bumpy_pkg::SPEED;
			n++;
			compare_value("offset_topleft_y", offset_topleft_y, to_pixel(y_model));
		end
		if (!hit_seen) begin
			confirm(1'b0, "top_bounce: the sprite never reached the top border");
		end else begin
			compare_value("hit_edge", hit_code, bumpy_pkg::EDGE_TOP);
			confirm(y_model <= 0, "top_bounce: top hit reported before the border");
			compare_value("state", state, bumpy_pkg::s_bounce_from_top);
			hit_pix = to_pixel(y_model);
			repeat (frames) begin
				run_frame();
				y_model += bumpy_pkg::SPEED;
				compare_value("offset_topleft_y", offset_topleft_y, to_pixel(y_model));
			end
			confirm(offset_topleft_y > hit_pix, "top_bounce: sprite did not move down");
		end
		end_test("top_bounce");
	endtask

	task automatic right_bounce();
		int frames;
		int n;
		int hit_pix;
		logic done;
		frames = pick_frames();
		apply_reset();
		x_model = bumpy_pkg::START_FIX;
		key_right = 1'b1;
		repeat (3) @(negedge clk);
		n = 0;
		done = 1'b0;
		// floor bounces on the way are ignored, only the right border counts
		while (!done && n < LONG_RUN_FRAMES) begin
			run_frame();
			x_model += bumpy_pkg::SPEED;
			n++;
			compare_value("offset_topleft_x", offset_topleft_x, to_pixel(x_model));
			done = hit_seen && (hit_code == bumpy_pkg::EDGE_RIGHT);
		end
		if (!done) begin
			confirm(1'b0, "right_bounce: the sprite never reached the right border");
		end else begin
			confirm(x_model + bumpy_pkg::BUMPY_SIZE_FIX >
				bumpy_pkg::FRAME_W_FIX - bumpy_pkg::BORDER_OFFSET,
				"right_bounce: right hit reported before the border");
			compare_value("state", state, bumpy_pkg::s_bounce_from_right);
			hit_pix = to_pixel(x_model);
			repeat (frames) begin
				run_frame();
				x_model -= bumpy_pkg::SPEED;
				compare_value("offset_topleft_x", offset_topleft_x, to_pixel(x_model));
			end
			confirm(offset_topleft_x < hit_pix, "right_bounce: sprite did not move back left");
		end
		end_test("right_bounce");
	endtask

	task automatic floor_bounce();
		int n;
		int floor_pix;
		int top_pix;
		logic first_hit;
		logic second_hit;
		apply_reset();
		y_model = bumpy_pkg::START_FIX;
		n = 0;
		first_hit = 1'b0;
		while (!first_hit && n < LONG_RUN_FRAMES) begin
			run_frame();
			y_model += bumpy_pkg::SPEED;
			n++;
			compare_value("offset_topleft_y", offset_topleft_y, to_pixel(y_model));
			first_hit = hit_seen && (hit_code == bumpy_pkg::EDGE_BOTTOM);
		end
		if (!first_hit) begin
			confirm(1'b0, "floor_bounce: the sprite never landed on the bottom border");
		end else begin
			confirm(y_model + bumpy_pkg::BUMPY_SIZE_FIX >= bumpy_pkg::FRAME_H_FIX,
				"floor_bounce: bottom hit reported above the floor");
			floor_pix = to_pixel(y_model);
			top_pix = floor_pix;
			n = 0;
			second_hit = 1'b0;
			while (!second_hit && n < SHORT_RUN_FRAMES) begin
				run_frame();
				n++;
				if (offset_topleft_y < top_pix)
					top_pix = offset_topleft_y;
				second_hit = hit_seen && (hit_code == bumpy_pkg::EDGE_BOTTOM);
			end
			confirm(top_pix < floor_pix, "floor_bounce: the sprite never left the floor");
			// one pixel of rounding allowed on top of the rise
			confirm((floor_pix - top_pix) * (1 << bumpy_pkg::FIXED_SHIFT) <=
				bumpy_pkg::JUMP_LIMIT + bumpy_pkg::SPEED + (1 << bumpy_pkg::FIXED_SHIFT) - 1,
				"floor_bounce: the jump rose higher than its limit");
			confirm(second_hit, "floor_bounce: no second landing after the jump");
		end
		end_test("floor_bounce");
	endtask

	task automatic die_and_revive();
		int frames;
		frames = pick_frames();
		apply_reset();
		key_die = 1'b1;
		repeat (3) @(negedge clk);
		key_die = 1'b0;
		compare_value("dead_flag", dead_flag, 1);
		compare_value("state", state, bumpy_pkg::s_die);
		repeat (frames) begin
			run_frame();
			compare_value("offset_topleft_x", offset_topleft_x, to_pixel(bumpy_pkg::START_FIX));
			compare_value("offset_topleft_y", offset_topleft_y, to_pixel(bumpy_pkg::START_FIX));
		end
		key_down = 1'b1;
		repeat (3) @(negedge clk);
		key_down = 1'b0;
		compare_value("dead_flag", dead_flag, 0);
		compare_value("state", state, bumpy_pkg::s_down);
		end_test("die");
	endtask

	initial begin
		resetN = 1'b0;
		start_of_frame = 1'b0;
		key_left = 1'b0;
		key_right = 1'b0;
		key_up = 1'b0;
		key_down = 1'b0;
		key_die = 1'b0;
		seed = 41;
		reset_values();
		walk_right();
		top_bounce();
		right_bounce();
		floor_bounce();
		die_and_revive();
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bumpy_top.sv
`timescale 1ns/1ps
`default_nettype none

module bumpy_top (
	input  logic clk,
	input  logic resetN,
	input  logic start_of_frame,
	input  logic key_left,
	input  logic key_right,
	input  logic key_up,
	input  logic key_down,
	input  logic key_die,
	output bumpy_pkg::pix_t offset_topleft_x,
	output bumpy_pkg::pix_t offset_topleft_y,
	output logic collision,
	output bumpy_pkg::edge_t hit_edge,
	output bumpy_pkg::bumpy_state_t state,
	output logic dead_flag
);

	bumpy_pkg::fix_t pos_x;
	bumpy_pkg::fix_t pos_y;
	logic pos_valid;

	bumpy_control control0 (
		.clk (clk),
		.resetN (resetN),
		.key_left (key_left),
		.key_right (key_right),
		.key_up (key_up),
		.key_down (key_down),
		.key_die (key_die),
		.collision (collision),
		.hit_edge (hit_edge),
		.state (state)
	);

	bumpy_move move0 (
		.clk (clk),
		.resetN (resetN),
		.start_of_frame (start_of_frame),
		.state (state),
		.collision (collision),
		.hit_edge (hit_edge),
		.pos_x (pos_x),
		.pos_y (pos_y),
		.offset_topleft_x (offset_topleft_x),
		.offset_topleft_y (offset_topleft_y),
		.pos_valid (pos_valid),
		.dead_flag (dead_flag)
	);

	// border check one cycle after each position update
	bumpy_hit_detect hit0 (
		.clk (clk),
		.resetN (resetN),
		.pos_valid (pos_valid),
		.pos_x (pos_x),
		.pos_y (pos_y),
		.collision (collision),
		.hit_edge (hit_edge)
	);

endmodule

`default_nettype wire

// File: sim.f
bumpy_pkg.sv
bumpy_control.sv
bumpy_move.sv
bumpy_hit_detect.sv
bumpy_top.sv
bumpy_tb.sv
